/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --timescale 1ns/100ps
TOP       = controlUnitTb
FILELIST  = list.f
OBJDIR    = obj_dir
PASS      = Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The simulation passes only if the pass line appears in its output.
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@output="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJDIR)

/* list.f */
+incdir+verilog
+incdir+tb
verilog/controlPkg.sv
verilog/instructionDecoder.sv
verilog/stepCounter.sv
verilog/controlSequencer.sv
verilog/controlWordTable.sv
verilog/controlUnit.sv
tb/controlUnitTb.sv

/* tb/controlUnitVectors.svh */
`ifndef CONTROL_UNIT_VECTORS_SVH
`define CONTROL_UNIT_VECTORS_SVH

// One instruction per entry. State is the execute state the unit must enter, and
// length is the number of execute cycles that are checked after the six fetch cycles.
typedef struct packed {
    logic [5:0]              opcode;
    logic [5:0]              funct;
    controlPkg::controlState state;
    logic [3:0]              length;
} testVector;

localparam int VECTOR_COUNT = 13;

localparam testVector VECTORS [VECTOR_COUNT] = '{
    '{`OP_RTYPE, `FUNCT_ADD,  controlPkg::stAdd,   4'd2},
    '{`OP_RTYPE, `FUNCT_SUB,  controlPkg::stSub,   4'd2},
    '{`OP_RTYPE, 6'd5,        controlPkg::stFetch, 4'd0}, // Funct 5 is not decoded.
    '{`OP_RTYPE, `FUNCT_AND,  controlPkg::stAnd,   4'd2},
    '{`OP_ADDI,  6'd17,       controlPkg::stAddi,  4'd2},
    '{`OP_RTYPE, `FUNCT_SLT,  controlPkg::stSlt,   4'd1},
    '{`OP_RTYPE, `FUNCT_SLL,  controlPkg::stSll,   4'd3},
    '{`OP_RTYPE, `FUNCT_SRL,  controlPkg::stSrl,   4'd3},
    '{6'd20,     6'd9,        controlPkg::stFetch, 4'd0}, // Opcode 20 is not decoded.
    '{`OP_RTYPE, `FUNCT_SRA,  controlPkg::stSra,   4'd3},
    '{`OP_RTYPE, `FUNCT_SLLV, controlPkg::stSllv,  4'd3},
    '{`OP_RTYPE, `FUNCT_SRAV, controlPkg::stSrav,  4'd3},
    // Halt is observed for ten cycles and must stay last.
    '{`OP_RESET, 6'd0,        controlPkg::stHalt,  4'd10}
};

string vectorNames [VECTOR_COUNT] = '{
    "add",
    "sub",
    "unknown funct",
    "and",
    "addi",
    "slt",
    "sll",
    "srl",
    "unknown opcode",
    "sra",
    "sllv",
    "srav",
    "halt"
};

`endif

/* tb/controlUnitTb.sv */
`include "control_settings.svh"

module controlUnitTb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                   clock;
    logic                   reset;
    controlPkg::instrWord   instruction;
    controlPkg::controlWord control;
    logic                   resetRequest;
    logic [31:0]            lfsrState;
    int                     errorCount;
    int                     testErrors;
    int                     testCount;
    int                     failedTests;

    `include "controlUnitVectors.svh"

    controlUnit dut0 (
        .clock        (clock),
        .reset        (reset),
        .instruction  (instruction),
        .control      (control),
        .resetRequest (resetRequest)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [31:0] lfsrStep(input logic [31:0] value);
        if (value[0]) begin
            return (value >> 1) ^ 32'hD0000001; // Taps 32, 31, 29 and 1.
        end
        return value >> 1;
    endfunction

    // Register fields of the instruction come from here, one LFSR step per bit.
    function automatic logic [4:0] randomField();
        logic [4:0] bits;
        for (int i = 0; i < 5; i++) begin
            bits[i]   = lfsrState[0];
            lfsrState = lfsrStep(lfsrState);
        end
        return bits;
    endfunction

    function automatic controlPkg::controlWord expectedWord(input controlPkg::controlState st,
                                                            input int step);
        controlPkg::controlWord w;
        w = '0;
        if (st == controlPkg::stFetch) begin
            if (step <= 3) begin
                w.aluOp   = `ALU_ADD;
                w.aluSrcB = 2'd1;
            end
            if (step == 3) begin
                w.pcWrite = 1'b1;
                w.irWrite = 1'b1;
            end
            if (step == 4) begin
                w.aWrite  = 1'b1;
                w.bWrite  = 1'b1;
                w.aluSrcB = 2'd1;
            end
        end else if (st inside {controlPkg::stAdd, controlPkg::stSub, controlPkg::stAnd}) begin
            w.aluOp = (st == controlPkg::stAdd) ? `ALU_ADD :
                      (st == controlPkg::stSub) ? `ALU_SUB : `ALU_AND;
            w.aluOutWrite = 1'b1;
            w.aluSrcA     = 1'b1;
            w.regWrite    = (step == 1);
            w.regDst      = (step == 1) ? 2'd1 : 2'd0;
        end else if (st == controlPkg::stAddi) begin
            w.aluSrcA = 1'b1;
            if (step == 0) begin
                w.aluOp       = `ALU_SUB;
                w.aluOutWrite = 1'b1;
                w.aluSrcB     = 2'd2;
            end else begin
                w.aluOp    = `ALU_ADD;
                w.regWrite = 1'b1;
            end
        end else if (st == controlPkg::stSlt) begin
            w.regWrite = 1'b1;
            w.aluOp    = `ALU_SLT;
            w.aluSrcA  = 1'b1;
            w.regDst   = 2'd1;
            w.memToReg = `MEM_TO_REG_SLT;
        end else if (st != controlPkg::stHalt) begin
            w.regDst   = 2'd1; // Every shift state writes back the shifter.
            w.memToReg = `MEM_TO_REG_SHIFT;
            if (step == 0) begin
                w.shiftOp     = `SHIFT_LOAD;
                w.shiftAmtSel = st inside {controlPkg::stSll, controlPkg::stSrl, controlPkg::stSra};
                w.shiftSrcSel = w.shiftAmtSel;
            end else if (step == 1) begin
                if (st == controlPkg::stSrl) begin
                    w.shiftOp = `SHIFT_RIGHT;
                end else if (st == controlPkg::stSra || st == controlPkg::stSrav) begin
                    w.shiftOp = `SHIFT_ARITH;
                end else begin
                    w.shiftOp = `SHIFT_LEFT;
                end
            end else begin
                w.shiftOp  = `SHIFT_LEFT;
                w.regWrite = 1'b1;
            end
        end
        return w;
    endfunction

    task automatic checkOutputs(input controlPkg::controlWord wantWord, input logic wantRequest,
                                input string where);
        assert (control == wantWord) else begin
            $display("mismatch at %0t ns: %s control %h, expected %h",
                     $time, where, control, wantWord);
            testErrors++;
        end
        assert (resetRequest == wantRequest) else begin
            $display("mismatch at %0t ns: %s resetRequest %b, expected %b",
                     $time, where, resetRequest, wantRequest);
            testErrors++;
        end
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (testErrors == 0) begin
            $display("PASS %s", name);
        end else begin
            $display("FAIL %s with %0d errors", name, testErrors);
            failedTests++;
        end
        errorCount += testErrors;
        testErrors = 0;
    endtask

    // Six fetch cycles, then the execute cycles of the entry.
    task automatic runVector(input int index);
        controlPkg::instrWord   word;
        controlPkg::controlWord want;
        int                     total;
        word.rType.opcode = VECTORS[index].opcode;
        word.rType.rs     = randomField();
        word.rType.rt     = randomField();
        word.rType.rd     = randomField();
        word.rType.shamt  = randomField();
        word.rType.funct  = VECTORS[index].funct;
        total = 6 + int'(VECTORS[index].length);
        for (int c = 0; c < total; c++) begin
            @(posedge clock);
            if (c == 0) begin
                instruction <= word; // Held until the next entry starts.
            end
            @(negedge clock);
            if (c < 6) begin
                want = expectedWord(controlPkg::stFetch, c);
            end else begin
                want = expectedWord(VECTORS[index].state, c - 6);
            end
            checkOutputs(want, (VECTORS[index].state == controlPkg::stHalt) && (c >= 5),
                         $sformatf("%s cycle %0d", vectorNames[index], c));
        end
        finishTest(vectorNames[index]);
    endtask

    initial begin
        reset       = 1'b1;
        instruction = '0;
        lfsrState   = 32'd92626;
        errorCount  = 0;
        testErrors  = 0;
        testCount   = 0;
        failedTests = 0;
        // A held reset alternates between halt and fetch, halt first.
        for (int i = 1; i <= 8; i++) begin
            @(posedge clock);
            if (i == 8) begin
                reset <= 1'b0;
            end
            @(negedge clock);
            checkOutputs('0, (i % 2) == 1, $sformatf("reset cycle %0d", i));
        end
        finishTest("reset");
        for (int k = 0; k < VECTOR_COUNT; k++) begin
            runVector(k);
        end
        $display("%0d tests run, %0d failed, %0d checks failed",
                 testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        int limit;
        limit = 8;
        for (int k = 0; k < VECTOR_COUNT; k++) begin
            limit += 6 + int'(VECTORS[k].length);
        end
        limit *= 2;
        repeat (limit) @(posedge clock);
        $display("Watchdog expired after %0d cycles, the tests did not finish.", limit);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* verilog/controlPkg.sv */
`include "control_settings.svh"

package controlPkg;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeFields;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [`INSTR_WIDTH-17:0] immediate; // Everything below the two register fields.
    } iTypeFields;

    // The same word seen as a register or an immediate instruction.
    typedef union packed {
        rTypeFields rType;
        iTypeFields iType;
    } instrWord;

    typedef enum logic [3:0] {
        opNone,
        opAdd,
        opSub,
        opAnd,
        opSlt,
        opSll,
        opSrl,
        opSra,
        opSllv,
        opSrav,
        opAddi,
        opHalt
    } operation;

    typedef enum logic [3:0] {
        stFetch,
        stAdd,
        stAddi,
        stSub,
        stAnd,
        stSll,
        stSlt,
        stSra,
        stSrl,
        stSllv,
        stSrav,
        stHalt
    } controlState;

    typedef struct packed {
        logic       pcWrite;
        logic       irWrite;
        logic       regWrite;
        logic       aWrite;
        logic       bWrite;
        logic [2:0] aluOp;
        logic       aluOutWrite;
        logic       aluSrcA;
        logic [1:0] aluSrcB;
        logic [1:0] regDst;
        logic [3:0] memToReg;
        logic       shiftAmtSel;
        logic       shiftSrcSel;
        logic [2:0] shiftOp;
    } controlWord;

    // Number of cycles spent in each state.
    function automatic logic [`STEP_WIDTH-1:0] stateLength(controlState state);
        case (state)
            stFetch: return `STEP_WIDTH'd6;
            stSll, stSrl, stSra, stSllv, stSrav: return `STEP_WIDTH'd3;
            stAdd, stSub, stAnd, stAddi: return `STEP_WIDTH'd2;
            default: return `STEP_WIDTH'd1; // slt and halt
        endcase
    endfunction

endpackage

/* verilog/controlSequencer.sv */
module controlSequencer (
    input  logic                    clock,
    input  logic                    reset,
    input  controlPkg::operation    op,
    input  logic                    lastStep,
    output controlPkg::controlState state,
    output logic                    resetRequest
);

    controlPkg::controlState nextState;

    always_comb begin
        nextState = state;
        if (lastStep) begin
            case (state)
                controlPkg::stFetch: begin
                    case (op)
                        controlPkg::opAdd:  nextState = controlPkg::stAdd;
                        controlPkg::opSub:  nextState = controlPkg::stSub;
                        controlPkg::opAnd:  nextState = controlPkg::stAnd;
                        controlPkg::opSlt:  nextState = controlPkg::stSlt;
                        controlPkg::opSll:  nextState = controlPkg::stSll;
                        controlPkg::opSrl:  nextState = controlPkg::stSrl;
                        controlPkg::opSra:  nextState = controlPkg::stSra;
                        controlPkg::opSllv: nextState = controlPkg::stSllv;
                        controlPkg::opSrav: nextState = controlPkg::stSrav;
                        controlPkg::opAddi: nextState = controlPkg::stAddi;
                        controlPkg::opHalt: nextState = controlPkg::stHalt;
                        default:            nextState = controlPkg::stFetch;
                    endcase
                end
                controlPkg::stHalt: begin
                    nextState = controlPkg::stHalt; // Only reset leaves halt.
                end
                default: begin
                    nextState = controlPkg::stFetch;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // A held reset toggles between halt and fetch.
            if (state == controlPkg::stHalt) begin
                state        <= controlPkg::stFetch;
                resetRequest <= 1'b0;
            end else begin
                state        <= controlPkg::stHalt;
                resetRequest <= 1'b1;
            end
        end else begin
            state        <= nextState;
            resetRequest <= (nextState == controlPkg::stHalt);
        end
    end

endmodule

/* verilog/controlUnit.sv */
`include "control_settings.svh"

module controlUnit (
    input  logic                   clock,
    input  logic                   reset,
    input  controlPkg::instrWord   instruction,
    output controlPkg::controlWord control,
    output logic                   resetRequest
);

    controlPkg::operation    op;
    controlPkg::controlState state;
    logic [`STEP_WIDTH-1:0]  step;
    logic                    lastStep;

    instructionDecoder decoder0 (
        .instruction (instruction),
        .op          (op)
    );

    controlSequencer sequencer0 (
        .clock        (clock),
        .reset        (reset),
        .op           (op),
        .lastStep     (lastStep),
        .state        (state),
        .resetRequest (resetRequest)
    );

    stepCounter counter0 (
        .clock    (clock),
        .reset    (reset),
        .state    (state),
        .step     (step),
        .lastStep (lastStep)
    );

    controlWordTable table0 (
        .clock   (clock),
        .reset   (reset),
        .state   (state),
        .step    (step),
        .control (control)
    );

endmodule

/* verilog/controlWordTable.sv */
`include "control_settings.svh"

module controlWordTable (
    input  logic                    clock,
    input  logic                    reset,
    input  controlPkg::controlState state,
    input  logic [`STEP_WIDTH-1:0]  step,
    output controlPkg::controlWord  control
);

    controlPkg::controlWord row;
    logic                   immediateShift;
    logic [2:0]             shiftDirection;
    logic [2:0]             aluFunction;

    // Shift amount and source come from the instruction only for sll, srl and sra.
    assign immediateShift = (state == controlPkg::stSll) || (state == controlPkg::stSrl)
                         || (state == controlPkg::stSra);

    always_comb begin
        case (state)
            controlPkg::stSrl:                     shiftDirection = `SHIFT_RIGHT;
            controlPkg::stSra, controlPkg::stSrav: shiftDirection = `SHIFT_ARITH;
            default:                               shiftDirection = `SHIFT_LEFT;
        endcase
    end

    always_comb begin
        case (state)
            controlPkg::stSub: aluFunction = `ALU_SUB;
            controlPkg::stAnd: aluFunction = `ALU_AND;
            default:           aluFunction = `ALU_ADD;
        endcase
    end

    always_comb begin
        row = '0;
        case (state)
            controlPkg::stFetch: begin
                case (step)
                    3'd0, 3'd1, 3'd2: begin
                        row.aluOp   = `ALU_ADD;
                        row.aluSrcB = 2'd1;
                    end
                    3'd3: begin
                        row.aluOp   = `ALU_ADD;
                        row.aluSrcB = 2'd1;
                        row.pcWrite = 1'b1;
                        row.irWrite = 1'b1; // Instruction register loads here.
                    end
                    3'd4: begin
                        row.aWrite  = 1'b1;
                        row.bWrite  = 1'b1;
                        row.aluSrcB = 2'd1;
                    end
                    default: ;
                endcase
            end
            controlPkg::stAdd, controlPkg::stSub, controlPkg::stAnd: begin
                row.aluOp       = aluFunction;
                row.aluOutWrite = 1'b1;
                row.aluSrcA     = 1'b1;
                if (step == 3'd1) begin
                    row.regWrite = 1'b1;
                    row.regDst   = 2'd1;
                end
            end
            controlPkg::stAddi: begin
                // The first step runs a subtract with the immediate operand.
                if (step == 3'd0) begin
                    row.aluOp       = `ALU_SUB;
                    row.aluOutWrite = 1'b1;
                    row.aluSrcA     = 1'b1;
                    row.aluSrcB     = 2'd2;
                end else begin
                    row.regWrite = 1'b1;
                    row.aluOp    = `ALU_ADD;
                    row.aluSrcA  = 1'b1;
                end
            end
            controlPkg::stSlt: begin
                row.regWrite = 1'b1;
                row.aluOp    = `ALU_SLT;
                row.aluSrcA  = 1'b1;
                row.regDst   = 2'd1;
                row.memToReg = `MEM_TO_REG_SLT;
            end
            controlPkg::stSll, controlPkg::stSrl, controlPkg::stSra,
            controlPkg::stSllv, controlPkg::stSrav: begin
                row.regDst   = 2'd1;
                row.memToReg = `MEM_TO_REG_SHIFT;
                case (step)
                    3'd0: begin
                        row.shiftAmtSel = immediateShift;
                        row.shiftSrcSel = immediateShift;
                        row.shiftOp     = `SHIFT_LOAD;
                    end
                    3'd1: row.shiftOp = shiftDirection;
                    default: begin
                        row.shiftOp  = `SHIFT_LEFT;
                        row.regWrite = 1'b1;
                    end
                endcase
            end
            default: ; // Halt drives nothing.
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            control <= '0;
        end else begin
            control <= row;
        end
    end

endmodule

/* verilog/control_settings.svh */
`ifndef CONTROL_SETTINGS_SVH
`define CONTROL_SETTINGS_SVH

// Instruction word and step counter widths.
`define INSTR_WIDTH 32
`define STEP_WIDTH  3

// Opcodes.
`define OP_RTYPE 6'd0
`define OP_ADDI  6'd8
`define OP_RESET 6'd63

// Funct codes of the R-type word.
`define FUNCT_ADD  6'd32
`define FUNCT_SUB  6'd34
`define FUNCT_AND  6'd36
`define FUNCT_SLL  6'd0
`define FUNCT_SLT  6'd42
`define FUNCT_SRA  6'd3
`define FUNCT_SRL  6'd2
`define FUNCT_SLLV 6'd4
`define FUNCT_SRAV 6'd7

// ALU operation codes.
`define ALU_ADD 3'd1
`define ALU_SUB 3'd2
`define ALU_AND 3'd3
`define ALU_SLT 3'd7

// Shifter commands.
`define SHIFT_LOAD  3'd1
`define SHIFT_LEFT  3'd2
`define SHIFT_RIGHT 3'd3
`define SHIFT_ARITH 3'd4

// Write-back source select.
`define MEM_TO_REG_SLT   4'd4
`define MEM_TO_REG_SHIFT 4'd8

`endif

/* verilog/instructionDecoder.sv */
`include "control_settings.svh"

module instructionDecoder (
    input  controlPkg::instrWord instruction,
    output controlPkg::operation op
);

    always_comb begin
        op = controlPkg::opNone; // Unknown words restart fetch.
        case (instruction.iType.opcode)
            `OP_RTYPE: begin
                case (instruction.rType.funct)
                    `FUNCT_ADD:  op = controlPkg::opAdd;
                    `FUNCT_SUB:  op = controlPkg::opSub;
                    `FUNCT_AND:  op = controlPkg::opAnd;
                    `FUNCT_SLT:  op = controlPkg::opSlt;
                    `FUNCT_SLL:  op = controlPkg::opSll;
                    `FUNCT_SRL:  op = controlPkg::opSrl;
                    `FUNCT_SRA:  op = controlPkg::opSra;
                    `FUNCT_SLLV: op = controlPkg::opSllv;
                    `FUNCT_SRAV: op = controlPkg::opSrav;
                    default:     op = controlPkg::opNone;
                endcase
            end
            `OP_ADDI: begin
                op = controlPkg::opAddi;
            end
            `OP_RESET: begin
                op = controlPkg::opHalt;
            end
            default: begin
                op = controlPkg::opNone;
            end
        endcase
    end

endmodule

/* verilog/stepCounter.sv */
`include "control_settings.svh"

module stepCounter (
    input  logic                    clock,
    input  logic                    reset,
    input  controlPkg::controlState state,
    output logic [`STEP_WIDTH-1:0]  step,
    output logic                    lastStep
);

    logic [`STEP_WIDTH-1:0] length;

    assign length = controlPkg::stateLength(state);

    // The sequencer moves on when this is high.
    assign lastStep = (step == length - 1'b1);

    always_ff @(posedge clock) begin
        if (reset) begin
            step <= '0;
        end else if (lastStep) begin
            step <= '0;
        end else begin
            step <= step + 1'b1;
        end
    end

endmodule
